// File: mc_dram_bridge_stimulus.txt
# kind: 0 idle, 1 config, 2 request, 3 read done; lane: 0 or 1; remaining columns hex
# kind lane cid cord ba bg ro co bo exp_ch exp_addr (request fields cache order, read done sim order)
0 0 0 00 0 0 0000 00 00 0 0000000
0 0 0 00 0 0 0000 00 00 0 0000000
2 0 0 04 1 0 0001 01 01 2 0008821
3 0 0 00 1 1 0002 03 04 0 A001064
0 0 0 00 0 0 0000 00 00 0 0000000
1 0 0 00 0 0 0000 00 00 0 0000000
0 0 0 00 0 0 0000 00 00 0 0000000
2 1 1 0b 2 1 1234 15 0a 5 91A32AA
2 0 1 0b 2 1 1234 15 0a 5 91A32AA
0 0 0 00 0 0 0000 00 00 0 0000000
0 0 0 00 0 0 0000 00 00 0 0000000
2 1 1 0b 2 1 1234 15 0a 5 91A32AA
0 0 0 00 0 0 0000 00 00 0 0000000
0 0 0 00 0 0 0000 00 00 0 0000000
3 0 0 00 2 1 1234 15 0a 0 1291A2AA
0 0 0 00 0 0 0000 00 00 0 0000000
3 0 0 00 3 0 0001 00 1f 0 1800081F
3 0 0 00 0 2 3fff 3f 00 0 5FFFFE0
0 0 0 00 0 0 0000 00 00 0 0000000
2 0 3 7f 3 3 3fff 3f 1f 7 1FFFFFFF
2 1 0 00 0 0 0000 00 00 0 0000000
2 0 2 36 1 2 2aaa 2a 15 3 15554D55
2 1 1 4a 0 3 0100 01 00 5 0806020
2 0 0 11 2 0 0fed 10 03 0 7F69203
2 1 3 0e 1 1 0042 2c 1e 7 0212D9E
3 0 0 00 1 3 2000 20 10 0 F000410
0 0 0 00 0 0 0000 00 00 0 0000000
0 0 0 00 0 0 0000 00 00 0 0000000

// File: mc_dram_bridge.f
+incdir+.
mc_dram_pkg.sv
mc_reset_seq.sv
wh_hdr_decode.sv
dram_addr_remap.sv
mc_dram_bridge.sv
mc_dram_bridge_properties.sv
mc_dram_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the bridge testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module mc_dram_bridge_tb \
  -f mc_dram_bridge.f > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vmc_dram_bridge_tb > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

grep -qF '*** FAILED ***' sim.log && { echo "result: fail"; exit 1; }
grep -qF '*** PASSED ***' sim.log && { echo "result: pass"; exit 0; }
echo "result: no verdict found in sim.log"
exit 1

// File: mc_dram_bridge_tb.sv
/*
 * manycore dram bridge testbench
 * replays file records one per cycle and checks ready release,
 * request remap and read-done restore at their fixed latencies
 */

`timescale 1ns/100ps

`include "mc_dram_bridge_defines.svh"

module mc_dram_bridge_tb;

  import mc_dram_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY = 2;
  localparam int DRAIN_CYCLES = 6;
  localparam int REQ_LATENCY = 2;
  localparam int RD_LATENCY = 1;
  localparam string STIM_FILE = "mc_dram_bridge_stimulus.txt";

  // record kinds in the stimulus file
  localparam int KIND_IDLE = 0;
  localparam int KIND_CONFIG = 1;
  localparam int KIND_REQ = 2;
  localparam int KIND_RD_DONE = 3;

  logic clk;
  logic arst_n;
  logic config_done;
  logic req_v;
  logic req_lane;
  logic [`MC_FLIT_W-1:0] req_flit;
  logic rd_done_v;
  dram_ch_addr_u rd_done_addr;
  logic bridge_ready;
  logic dram_req_v;
  logic [`MC_CH_ID_W-1:0] dram_req_ch;
  dram_ch_addr_u dram_req_addr;
  logic rd_done_v_out;
  dram_ch_addr_u rd_done_addr_out;

  // records as loaded with the header word already packed
  int rec_kind[$];
  logic rec_lane[$];
  logic [`MC_FLIT_W-1:0] rec_word[$];
  logic [`MC_CH_ID_W-1:0] rec_ch[$];
  dram_ch_addr_u rec_exp[$];
  bit records_loaded = 1'b0;

  int cycle;
  bit cfg_seen;
  int cfg_cycle;

  // outputs still pending along with their due cycles
  int req_due_q[$];
  logic [`MC_CH_ID_W-1:0] req_ch_q[$];
  dram_ch_addr_u req_addr_q[$];
  string req_name_q[$];
  int rd_due_q[$];
  dram_ch_addr_u rd_addr_q[$];
  string rd_name_q[$];

  mc_dram_bridge dut0 (
    .clk_i(clk)
    , .arst_n_i(arst_n)
    , .config_done_i(config_done)
    , .req_v_i(req_v)
    , .req_lane_i(req_lane)
    , .req_flit_i(req_flit)
    , .rd_done_v_i(rd_done_v)
    , .rd_done_addr_i(rd_done_addr)
    , .bridge_ready_o(bridge_ready)
    , .dram_req_v_o(dram_req_v)
    , .dram_req_ch_o(dram_req_ch)
    , .dram_req_addr_o(dram_req_addr)
    , .rd_done_v_o(rd_done_v_out)
    , .rd_done_addr_o(rd_done_addr_out)
  );

  bind mc_dram_bridge mc_dram_bridge_properties props0 (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .req_v_i(req_v_i)
    , .rd_done_v_i(rd_done_v_i)
    , .bridge_ready_i(bridge_ready_o)
    , .dram_req_v_i(dram_req_v_o)
    , .rd_done_out_v_i(rd_done_v_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // error and compare helpers

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected %0b actual %0b", name, exp, act));
    end
  endtask

  task automatic check_ch(input string name, input logic [`MC_CH_ID_W-1:0] exp,
                          input logic [`MC_CH_ID_W-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s channel expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input dram_ch_addr_u exp,
                            input dram_ch_addr_u act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s address expected %08h actual %08h", name, exp, act));
    end
  endtask

  // core reset leaves the chain MC_RESET_DEPTH cycles after config is driven
  function automatic logic ready_expected(input int at_cycle);
    return cfg_seen && (at_cycle >= cfg_cycle + `MC_RESET_DEPTH);
  endfunction

  ////////////////////
  // stimulus file

  task automatic load_records();
    int fd;
    int rc;
    int kind;
    int lane;
    int cid;
    int cord;
    int ba;
    int bg;
    int ro;
    int co;
    int bo;
    int ch;
    int exp_word;
    string line;
    dram_ch_addr_u fields;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      fail_run($sformatf("cannot open stimulus file %s", STIM_FILE));
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      rc = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h",
                   kind, lane, cid, cord, ba, bg, ro, co, bo, ch, exp_word);
      if (rc != 11 || kind < KIND_IDLE || kind > KIND_RD_DONE) begin
        fail_run($sformatf("stimulus line is malformed: %s", line));
      end
      fields = '0;
      // read-done fields come in simulator order and request fields in cache order
      if (kind == KIND_RD_DONE) begin
        fields.sim_view.ba = ba[`MC_BA_W-1:0];
        fields.sim_view.bg = bg[`MC_BG_W-1:0];
        fields.sim_view.ro = ro[`MC_RO_W-1:0];
        fields.sim_view.co = co[`MC_CO_W-1:0];
        fields.sim_view.bo = bo[`MC_BO_W-1:0];
      end else begin
        fields.cache_view.ba = ba[`MC_BA_W-1:0];
        fields.cache_view.bg = bg[`MC_BG_W-1:0];
        fields.cache_view.ro = ro[`MC_RO_W-1:0];
        fields.cache_view.co = co[`MC_CO_W-1:0];
        fields.cache_view.bo = bo[`MC_BO_W-1:0];
      end
      rec_kind.push_back(kind);
      rec_lane.push_back(lane[0]);
      rec_word.push_back({cid[`MC_CID_W-1:0], cord[`MC_CORD_W-1:0], fields});
      rec_ch.push_back(ch[`MC_CH_ID_W-1:0]);
      rec_exp.push_back(exp_word[`MC_CH_ADDR_W-1:0]);
    end
    $fclose(fd);
    if (rec_kind.size() == 0) begin
      fail_run("stimulus file holds no records");
    end
  endtask

  ////////////////////
  // per cycle drive and check

  task automatic drive_record(input int idx);
    logic [`MC_FLIT_W-1:0] word;
    word = rec_word[idx];
    req_v = 1'b0;
    rd_done_v = 1'b0;
    case (rec_kind[idx])
      KIND_CONFIG: begin
        config_done = 1'b1;
        if (!cfg_seen) begin
          cfg_seen = 1'b1;
          cfg_cycle = cycle;
        end
      end
      KIND_REQ: begin
        req_v = 1'b1;
        req_lane = rec_lane[idx];
        // odd lane travels inverted
        req_flit = rec_lane[idx] ? ~word : word;
        if (ready_expected(cycle)) begin
          req_due_q.push_back(cycle + REQ_LATENCY);
          req_ch_q.push_back(rec_ch[idx]);
          req_addr_q.push_back(rec_exp[idx]);
          req_name_q.push_back($sformatf("request record %0d", idx + 1));
        end
      end
      KIND_RD_DONE: begin
        rd_done_v = 1'b1;
        rd_done_addr = word[`MC_CH_ADDR_W-1:0];
        if (ready_expected(cycle)) begin
          rd_due_q.push_back(cycle + RD_LATENCY);
          rd_addr_q.push_back(rec_exp[idx]);
          rd_name_q.push_back($sformatf("read-done record %0d", idx + 1));
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_cycle();
    check_bit($sformatf("bridge ready cycle %0d", cycle), ready_expected(cycle), bridge_ready);
    if (req_due_q.size() > 0 && req_due_q[0] == cycle) begin
      check_bit($sformatf("%s valid", req_name_q[0]), 1'b1, dram_req_v);
      check_ch(req_name_q[0], req_ch_q[0], dram_req_ch);
      check_addr(req_name_q[0], req_addr_q[0], dram_req_addr);
      void'(req_due_q.pop_front());
      void'(req_ch_q.pop_front());
      void'(req_addr_q.pop_front());
      void'(req_name_q.pop_front());
    end else begin
      check_bit($sformatf("idle request valid cycle %0d", cycle), 1'b0, dram_req_v);
    end
    if (rd_due_q.size() > 0 && rd_due_q[0] == cycle) begin
      check_bit($sformatf("%s valid", rd_name_q[0]), 1'b1, rd_done_v_out);
      check_addr(rd_name_q[0], rd_addr_q[0], rd_done_addr_out);
      void'(rd_due_q.pop_front());
      void'(rd_addr_q.pop_front());
      void'(rd_name_q.pop_front());
    end else begin
      check_bit($sformatf("idle read-done valid cycle %0d", cycle), 1'b0, rd_done_v_out);
    end
  endtask

  ////////////////////
  // main sequence

  initial begin : main_seq
    clk = 1'b0;
    arst_n = 1'b0;
    config_done = 1'b0;
    req_v = 1'b0;
    req_lane = 1'b0;
    req_flit = '0;
    rd_done_v = 1'b0;
    rd_done_addr = '0;
    cycle = 0;
    cfg_seen = 1'b0;
    cfg_cycle = 0;
    load_records();
    records_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;
    @(negedge clk);
    // everything quiet and zero out of reset
    check_bit("reset ready", 1'b0, bridge_ready);
    check_bit("reset request valid", 1'b0, dram_req_v);
    check_bit("reset read-done valid", 1'b0, rd_done_v_out);
    check_ch("reset request", '0, dram_req_ch);
    check_addr("reset request", '0, dram_req_addr);
    check_addr("reset read-done", '0, rd_done_addr_out);
    for (int i = 0; i < rec_kind.size(); i++) begin
      @(posedge clk);
      cycle++;
      #DRIVE_DELAY;
      drive_record(i);
      @(negedge clk);
      check_cycle();
    end
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
      @(posedge clk);
      cycle++;
      #DRIVE_DELAY;
      req_v = 1'b0;
      rd_done_v = 1'b0;
      // ready holds until the next async reset even when config drops
      config_done = 1'b0;
      @(negedge clk);
      check_cycle();
    end
    if (req_due_q.size() == 0 && rd_due_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run("expected outputs never appeared before the end of the run");
    end
  end

  initial begin : watchdog
    int limit;
    wait (records_loaded);
    limit = rec_kind.size() * 4 + 100;
    repeat (limit) @(posedge clk);
    fail_run($sformatf("timeout, run did not finish within %0d cycles", limit));
  end

endmodule

// File: mc_dram_bridge_properties.sv
/*
 * bridge timing properties
 * output strobes follow their inputs at the fixed latencies and stay
 * low while the core is held in reset
 */

`timescale 1ns/100ps

module mc_dram_bridge_properties (
  input logic clk_i
  , input logic arst_n_i
  , input logic req_v_i
  , input logic rd_done_v_i
  , input logic bridge_ready_i
  , input logic dram_req_v_i
  , input logic rd_done_out_v_i
);

  ////////////////////
  // latency

  // decode stage then remap stage
  req_latency_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    dram_req_v_i |-> $past(req_v_i, 2)
  ) else $error("dram request valid without a request two cycles earlier");

  rd_latency_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    rd_done_out_v_i |-> $past(rd_done_v_i)
  ) else $error("read-done valid without a read done one cycle earlier");

  ////////////////////
  // reset gating

  ready_gate_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !bridge_ready_i |-> !(dram_req_v_i || rd_done_out_v_i)
  ) else $error("output valid while the bridge is not ready");

endmodule

// File: mc_dram_bridge.sv
/*
 * manycore dram bridge
 * reset release after configuration, header decode and address remap
 * toward the dram simulator, plus read-done address restore
 */

`timescale 1ns/100ps

`include "mc_dram_bridge_defines.svh"

module mc_dram_bridge (
  input logic clk_i
  , input logic arst_n_i
  , input logic config_done_i

  // wormhole header from one of the two ruche lanes
  , input logic req_v_i
  , input logic req_lane_i
  , input logic [`MC_FLIT_W-1:0] req_flit_i

  // read done from the simulator, sim order
  , input logic rd_done_v_i
  , input mc_dram_pkg::dram_ch_addr_u rd_done_addr_i

  , output logic bridge_ready_o

  , output logic dram_req_v_o
  , output logic [`MC_CH_ID_W-1:0] dram_req_ch_o
  , output mc_dram_pkg::dram_ch_addr_u dram_req_addr_o

  , output logic rd_done_v_o
  , output mc_dram_pkg::dram_ch_addr_u rd_done_addr_o
);

  import mc_dram_pkg::*;

  logic core_reset;
  logic hdr_v;
  logic [`MC_CH_ID_W-1:0] hdr_ch;
  dram_ch_addr_u hdr_addr;

  ////////////////////
  // reset release

  mc_reset_seq reset_seq0 (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .config_done_i(config_done_i)
    , .core_reset_o(core_reset)
    , .bridge_ready_o(bridge_ready_o)
  );

  ////////////////////
  // request path, two stages

  wh_hdr_decode hdr_dec0 (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .core_reset_i(core_reset)
    , .req_v_i(req_v_i)
    , .req_lane_i(req_lane_i)
    , .req_flit_i(req_flit_i)
    , .hdr_v_o(hdr_v)
    , .hdr_ch_o(hdr_ch)
    , .hdr_addr_o(hdr_addr)
  );

  // also carries the one-stage read-done path
  dram_addr_remap remap0 (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .core_reset_i(core_reset)
    , .hdr_v_i(hdr_v)
    , .hdr_ch_i(hdr_ch)
    , .hdr_addr_i(hdr_addr)
    , .rd_done_v_i(rd_done_v_i)
    , .rd_done_addr_i(rd_done_addr_i)
    , .dram_req_v_o(dram_req_v_o)
    , .dram_req_ch_o(dram_req_ch_o)
    , .dram_req_addr_o(dram_req_addr_o)
    , .rd_done_v_o(rd_done_v_o)
    , .rd_done_addr_o(rd_done_addr_o)
  );

endmodule

// File: dram_addr_remap.sv
/*
 * dram address remap
 * second request stage moves cache-order fields into simulator order;
 * the read-done path moves simulator-order addresses back into cache
 * order for the cache side
 */

`timescale 1ns/100ps

`include "mc_dram_bridge_defines.svh"

module dram_addr_remap (
  input logic clk_i
  , input logic arst_n_i
  , input logic core_reset_i

  , input logic hdr_v_i
  , input logic [`MC_CH_ID_W-1:0] hdr_ch_i
  , input mc_dram_pkg::dram_ch_addr_u hdr_addr_i

  , input logic rd_done_v_i
  , input mc_dram_pkg::dram_ch_addr_u rd_done_addr_i

  , output logic dram_req_v_o
  , output logic [`MC_CH_ID_W-1:0] dram_req_ch_o
  , output mc_dram_pkg::dram_ch_addr_u dram_req_addr_o

  , output logic rd_done_v_o
  , output mc_dram_pkg::dram_ch_addr_u rd_done_addr_o
);

  import mc_dram_pkg::*;

  dram_ch_addr_u req_addr_sim;
  dram_ch_addr_u rd_addr_cache;

  logic dram_req_v_r;
  logic [`MC_CH_ID_W-1:0] dram_req_ch_r;
  dram_ch_addr_u dram_req_addr_r;

  logic rd_done_v_r;
  dram_ch_addr_u rd_done_addr_r;

  ////////////////////
  // cache to simulator order

  always_comb begin
    req_addr_sim.sim_view.ro = hdr_addr_i.cache_view.ro;
    req_addr_sim.sim_view.bg = hdr_addr_i.cache_view.bg;
    req_addr_sim.sim_view.ba = hdr_addr_i.cache_view.ba;
    req_addr_sim.sim_view.co = hdr_addr_i.cache_view.co;
    req_addr_sim.sim_view.bo = hdr_addr_i.cache_view.bo;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dram_req_v_r <= 1'b0;
      dram_req_ch_r <= '0;
      dram_req_addr_r <= '0;
    end else begin
      dram_req_v_r <= hdr_v_i & ~core_reset_i;
      if (hdr_v_i) begin
        dram_req_ch_r <= hdr_ch_i;
        dram_req_addr_r <= req_addr_sim;
      end
    end
  end

  ////////////////////
  // read done, back to cache order

  always_comb begin
    rd_addr_cache.cache_view.ba = rd_done_addr_i.sim_view.ba;
    rd_addr_cache.cache_view.bg = rd_done_addr_i.sim_view.bg;
    rd_addr_cache.cache_view.ro = rd_done_addr_i.sim_view.ro;
    rd_addr_cache.cache_view.co = rd_done_addr_i.sim_view.co;
    rd_addr_cache.cache_view.bo = rd_done_addr_i.sim_view.bo;
  end

  // read done ignored while the core is in reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_done_v_r <= 1'b0;
      rd_done_addr_r <= '0;
    end else begin
      rd_done_v_r <= rd_done_v_i & ~core_reset_i;
      if (rd_done_v_i & ~core_reset_i) begin
        rd_done_addr_r <= rd_addr_cache;
      end
    end
  end

  assign dram_req_v_o = dram_req_v_r;
  assign dram_req_ch_o = dram_req_ch_r;
  assign dram_req_addr_o = dram_req_addr_r;
  assign rd_done_v_o = rd_done_v_r;
  assign rd_done_addr_o = rd_done_addr_r;

endmodule

// File: wh_hdr_decode.sv
/*
 * wormhole header decode
 * first request stage: undoes the odd ruche lane inversion, picks the
 * dram channel from the source coordinate and registers the
 * cache-order channel address
 */

`timescale 1ns/100ps

`include "mc_dram_bridge_defines.svh"

module wh_hdr_decode (
  input logic clk_i
  , input logic arst_n_i
  , input logic core_reset_i

  , input logic req_v_i
  , input logic req_lane_i
  , input logic [`MC_FLIT_W-1:0] req_flit_i

  , output logic hdr_v_o
  , output logic [`MC_CH_ID_W-1:0] hdr_ch_o
  , output mc_dram_pkg::dram_ch_addr_u hdr_addr_o
);

  import mc_dram_pkg::*;

  logic [`MC_FLIT_W-1:0] flit_fixed;
  logic [`MC_CORD_W-1:0] src_cord;
  logic [`MC_CH_ID_W-1:0] ch_id;
  dram_ch_addr_u cache_addr;
  logic accept;

  logic hdr_v_r;
  logic [`MC_CH_ID_W-1:0] hdr_ch_r;
  dram_ch_addr_u hdr_addr_r;

  ////////////////////
  // lane polarity

  // lane 1 travels bitwise inverted on the ruche wires
  assign flit_fixed = req_lane_i ? ~req_flit_i : req_flit_i;

  ////////////////////
  // field extraction

  assign src_cord = flit_fixed[`MC_CORD_LSB +: `MC_CORD_W];

  // skip the ruche bits, the next coordinate bits name the channel
  assign ch_id = src_cord[`MC_LG_RUCHE +: `MC_CH_ID_W];

  // low bits of the header already hold the cache-order address
  assign cache_addr = flit_fixed[`MC_CH_ADDR_W-1:0];

  // nothing is taken while the core is held in reset
  assign accept = req_v_i & ~core_reset_i;

  ////////////////////
  // stage register

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hdr_v_r <= 1'b0;
      hdr_ch_r <= '0;
      hdr_addr_r <= '0;
    end else begin
      hdr_v_r <= accept;
      // hold the last header when idle
      if (accept) begin
        hdr_ch_r <= ch_id;
        hdr_addr_r <= cache_addr;
      end
    end
  end

  assign hdr_v_o = hdr_v_r;
  assign hdr_ch_o = hdr_ch_r;
  assign hdr_addr_o = hdr_addr_r;

endmodule

// File: mc_reset_seq.sv
/*
 * core reset sequencer
 * holds the core in reset until configuration is done, then releases
 * it through a short register chain and flags the bridge as ready
 */

`timescale 1ns/100ps

`include "mc_dram_bridge_defines.svh"

module mc_reset_seq (
  input logic clk_i
  , input logic arst_n_i
  , input logic config_done_i
  , output logic core_reset_o
  , output logic bridge_ready_o
);

  logic [`MC_RESET_DEPTH-1:0] reset_chain_r;
  logic reset_in;

  // keep feeding reset while config is pending;
  // once the chain has drained, only zeros go in so ready sticks
  assign reset_in = ~config_done_i & reset_chain_r[`MC_RESET_DEPTH-1];

  ////////////////////
  // release chain

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reset_chain_r <= '1;
    end else begin
      reset_chain_r <= {reset_chain_r[`MC_RESET_DEPTH-2:0], reset_in};
    end
  end

  // last stage is the core reset seen by both request stages
  assign core_reset_o = reset_chain_r[`MC_RESET_DEPTH-1];
  assign bridge_ready_o = ~reset_chain_r[`MC_RESET_DEPTH-1];

endmodule

// File: mc_dram_pkg.sv
/*
 * memory bridge types
 * one dram channel address word, seen either in the order the cache dma
 * produces (ba, bg, ro, co, bo) or in the order the dram simulator
 * expects (ro, bg, ba, co, bo)
 */

`include "mc_dram_bridge_defines.svh"

package mc_dram_pkg;

  // both views span the same MC_CH_ADDR_W bits
  typedef union packed {
    // cache dma order, bank bits on top
    struct packed {
      logic [`MC_BA_W-1:0] ba;
      logic [`MC_BG_W-1:0] bg;
      logic [`MC_RO_W-1:0] ro;
      logic [`MC_CO_W-1:0] co;
      logic [`MC_BO_W-1:0] bo;
    } cache_view;

    // simulator order, row on top
    struct packed {
      logic [`MC_RO_W-1:0] ro;
      logic [`MC_BG_W-1:0] bg;
      logic [`MC_BA_W-1:0] ba;
      logic [`MC_CO_W-1:0] co;
      logic [`MC_BO_W-1:0] bo;
    } sim_view;
  } dram_ch_addr_u;

  // column and byte offset sit at the bottom in both orders,
  // only the upper three fields move

endpackage

// File: mc_dram_bridge_defines.svh
/*
 * memory bridge field widths
 * sizes of the dram channel address fields, the wormhole header layout,
 * the channel id slice and the reset release depth
 */

`ifndef MC_DRAM_BRIDGE_DEFINES_SVH
`define MC_DRAM_BRIDGE_DEFINES_SVH

////////////////////
// dram channel address fields

// bank address
`define MC_BA_W 2
// bank group
`define MC_BG_W 2
// row
`define MC_RO_W 14
// column
`define MC_CO_W 6
// byte offset within a dram word
`define MC_BO_W 5

`define MC_CH_ADDR_W (`MC_BA_W + `MC_BG_W + `MC_RO_W + `MC_CO_W + `MC_BO_W)

////////////////////
// wormhole header word
// address low, source coordinate above it, cid on top

`define MC_CORD_W 7
`define MC_CID_W 2
`define MC_FLIT_W (`MC_CH_ADDR_W + `MC_CORD_W + `MC_CID_W)
`define MC_CORD_LSB `MC_CH_ADDR_W

////////////////////
// channel select

// log2 of ruche factor, the low coordinate bits pick the lane
`define MC_LG_RUCHE 1
`define MC_CH_ID_W 3

////////////////////
// reset release

`define MC_RESET_DEPTH 3

`endif
